// ==== Makefile ====
TOP = tb_sdram_ctrl

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

obj_dir/V$(TOP): verilog.f *.sv
	verilator --binary --timing --assert -Wall -f verilog.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== sdram_bank_row.sv ====
/*
 Open-row tracker for one bank. Classifies the pending request's row
 as idle, hit or conflict. One instance per bank.
*/
`timescale 1ns/10ps

module sdram_bank_row (
	input  logic            i_clock,
	input  logic            i_reset,
	input  sdram_pkg::row_t i_pend_row,
	sdram_bank_if.tracker   trk
);
	logic            open_q;
	sdram_pkg::row_t row_q;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			open_q <= 1'b0;
			row_q  <= '0;
		end else begin
			if (trk.precharge || trk.precharge_all) begin
				open_q <= 1'b0;	// Close wins over activate.
			end else if (trk.activate) begin
				open_q <= 1'b1;
				row_q  <= i_pend_row;
			end
		end
	end

	// Status for the pending row.
	always_comb begin
		if (!open_q)
			trk.status = sdram_pkg::ROW_IDLE;
		else if (row_q == i_pend_row)
			trk.status = sdram_pkg::ROW_HIT;
		else
			trk.status = sdram_pkg::ROW_CONFLICT;
	end

	assign trk.open_row = row_q;

endmodule

// ==== sdram_cmd_seq.sv ====
/*
 Command sequencer. Runs chip power-up, periodic refresh and the
 activate, precharge, read and write bursts, and drives the chip pins.
*/
`timescale 1ns/10ps

module sdram_cmd_seq #(
	parameter int USER_DATA_WIDTH  = 32,
	parameter int SDRAM_DATA_WIDTH = 16,
	parameter int STARTUP_CYCLES   = 20000,
	parameter int REFRESH_INTERVAL = 500
) (
	input  logic                          i_clock,
	input  logic                          i_reset,
	sdram_req_if.seq                      req,
	sdram_bank_if.seq                     bank_if [sdram_pkg::NUM_BANKS],
	input  sdram_pkg::bank_t              i_pend_bank,
	output logic                          o_sdram_cke,
	output logic                          o_sdram_cs_n,
	output logic                          o_sdram_ras_n,
	output logic                          o_sdram_cas_n,
	output logic                          o_sdram_we_n,
	output logic [SDRAM_DATA_WIDTH/8-1:0] o_sdram_dqm,
	output sdram_pkg::bank_t              o_sdram_ba,
	output sdram_pkg::addr_bus_t          o_sdram_addr,
	output logic [SDRAM_DATA_WIDTH-1:0]   o_sdram_dq_out,
	output logic                          o_sdram_dq_oe,
	input  logic [SDRAM_DATA_WIDTH-1:0]   i_sdram_dq_in,
	output logic                          o_rsp_valid,
	output logic [USER_DATA_WIDTH-1:0]    o_rsp_rdata
);
	localparam int BURST_COUNT = USER_DATA_WIDTH / SDRAM_DATA_WIDTH;
	localparam int CNT_W       = $clog2(STARTUP_CYCLES + 16);
	localparam int REF_W       = $clog2(REFRESH_INTERVAL + 1);
	localparam int LEFT_W      = $clog2(BURST_COUNT + 1);
	localparam int CKE_AT      = (STARTUP_CYCLES * 3) / 4;	// Quarter of the wait gone.
	localparam int CAP_FIRST   = sdram_pkg::CAS_LATENCY + 1;
	localparam int PIPE_LEN    = CAP_FIRST + BURST_COUNT;
	localparam int RW_WAIT     = sdram_pkg::CAS_LATENCY + BURST_COUNT;

	typedef enum logic [3:0] {
		ST_STARTUP, ST_INIT_PRECHARGE, ST_INIT_REFRESH_1, ST_INIT_REFRESH_2,
		ST_INIT_SET_MODE, ST_IDLE, ST_PRECHARGE_ALL, ST_REFRESH,
		ST_PRECHARGE, ST_ACTIVATE, ST_READ, ST_WRITE, ST_WAIT
	} state_t;

	state_t                     state;
	state_t                     next_state;	// Where ST_WAIT goes.
	logic [CNT_W-1:0]           count;
	logic [REF_W-1:0]           refresh_cnt;
	logic                       refresh_due;
	logic                       any_open;
	sdram_pkg::cmd_t            cmd_q;
	sdram_pkg::bank_t           ba_q;
	sdram_pkg::addr_bus_t       addr_q;
	logic                       cke_q;
	sdram_pkg::row_state_t      bank_status [sdram_pkg::NUM_BANKS];
	sdram_pkg::row_t            bank_open_row [sdram_pkg::NUM_BANKS];
	logic [PIPE_LEN-1:0]        rd_pipe;
	logic [SDRAM_DATA_WIDTH-1:0] dq_in_q;
	logic [USER_DATA_WIDTH-1:0] rsp_shift;
	logic                       rsp_valid_q;
	logic [USER_DATA_WIDTH-1:0] wr_shift;
	logic [LEFT_W-1:0]          wr_left;
	logic                       dq_oe_q;
	logic [SDRAM_DATA_WIDTH-1:0] dq_out_q;

	// ==============================
	// Bank trackers
	// ==============================

	for (genvar b = 0; b < sdram_pkg::NUM_BANKS; b++) begin : g_bank
		assign bank_status[b]   = bank_if[b].status;
		assign bank_open_row[b] = bank_if[b].open_row;
		assign bank_if[b].activate  = (state == ST_ACTIVATE) && (i_pend_bank == 2'(b));
		assign bank_if[b].precharge = (state == ST_PRECHARGE) && (i_pend_bank == 2'(b));
		assign bank_if[b].precharge_all =
			(state == ST_INIT_PRECHARGE) || (state == ST_PRECHARGE_ALL);
	end

	always_comb begin
		any_open = 1'b0;
		for (int b = 0; b < sdram_pkg::NUM_BANKS; b++)
			any_open = any_open || (bank_status[b] != sdram_pkg::ROW_IDLE);
	end

	// Pops the slot at READ/WRITE. The pulse at SET_MODE opens the front end.
	assign req.ready = (state == ST_INIT_SET_MODE) || (state == ST_READ) || (state == ST_WRITE);

	// Refresh interval.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			refresh_cnt <= '0;
			refresh_due <= 1'b0;
		end else begin
			if (state == ST_REFRESH)
				refresh_due <= 1'b0;
			if (refresh_cnt == REF_W'(REFRESH_INTERVAL - 1)) begin
				refresh_cnt <= '0;
				refresh_due <= 1'b1;
			end else begin
				refresh_cnt <= refresh_cnt + 1'b1;
			end
		end
	end

	// ==============================
	// Main FSM
	// ==============================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state      <= ST_STARTUP;
			next_state <= ST_IDLE;
			count      <= CNT_W'(STARTUP_CYCLES);
			cmd_q      <= sdram_pkg::CMD_NOP;
			ba_q       <= '0;
			addr_q     <= '0;
			cke_q      <= 1'b0;
		end else begin
			cmd_q <= sdram_pkg::CMD_NOP;	// Commands last one cycle.
			case (state)
				ST_STARTUP: begin
					if (count <= CNT_W'(CKE_AT))
						cke_q <= 1'b1;
					if (count == '0)
						state <= ST_INIT_PRECHARGE;
					else
						count <= count - 1'b1;
				end
				ST_INIT_PRECHARGE, ST_PRECHARGE_ALL: begin
					cmd_q      <= sdram_pkg::CMD_PRECHARGE;
					addr_q     <= 13'h0400;	// A10 selects all banks.
					count      <= CNT_W'(sdram_pkg::T_RP);
					next_state <= (state == ST_PRECHARGE_ALL) ? ST_REFRESH : ST_INIT_REFRESH_1;
					state      <= ST_WAIT;
				end
				ST_INIT_REFRESH_1, ST_INIT_REFRESH_2, ST_REFRESH: begin
					cmd_q <= sdram_pkg::CMD_REFRESH;
					count <= CNT_W'(sdram_pkg::T_RFC);
					case (state)
						ST_INIT_REFRESH_1: next_state <= ST_INIT_REFRESH_2;
						ST_INIT_REFRESH_2: next_state <= ST_INIT_SET_MODE;
						default:           next_state <= ST_IDLE;
					endcase
					state <= ST_WAIT;
				end
				ST_INIT_SET_MODE: begin
					cmd_q      <= sdram_pkg::CMD_SET_MODE;
					ba_q       <= '0;
					addr_q     <= sdram_pkg::MODE_WORD(BURST_COUNT);
					count      <= CNT_W'(sdram_pkg::T_MRD);
					next_state <= ST_IDLE;
					state      <= ST_WAIT;
				end
				ST_IDLE: begin
					if (refresh_due) begin
						state <= any_open ? ST_PRECHARGE_ALL : ST_REFRESH;
					end else if (req.valid) begin
						case (bank_status[i_pend_bank])
							sdram_pkg::ROW_HIT:  state <= req.write ? ST_WRITE : ST_READ;
							sdram_pkg::ROW_IDLE: state <= ST_ACTIVATE;
							default:             state <= ST_PRECHARGE;
						endcase
					end
				end
				ST_PRECHARGE: begin
					cmd_q      <= sdram_pkg::CMD_PRECHARGE;
					ba_q       <= req.bank;
					addr_q     <= bank_open_row[i_pend_bank];
					addr_q[10] <= 1'b0;	// This bank only.
					count      <= CNT_W'(sdram_pkg::T_RP);
					next_state <= ST_ACTIVATE;
					state      <= ST_WAIT;
				end
				ST_ACTIVATE: begin
					cmd_q      <= sdram_pkg::CMD_ACTIVATE;
					ba_q       <= req.bank;
					addr_q     <= req.row;
					count      <= CNT_W'(sdram_pkg::T_ACT);
					next_state <= req.write ? ST_WRITE : ST_READ;
					state      <= ST_WAIT;
				end
				ST_READ, ST_WRITE: begin
					cmd_q      <= (state == ST_WRITE) ? sdram_pkg::CMD_WRITE : sdram_pkg::CMD_READ;
					ba_q       <= req.bank;
					addr_q     <= {4'b0000, req.col};	// A10 low, no auto-precharge.
					count      <= CNT_W'(RW_WAIT);	// Covers data and write recovery.
					next_state <= ST_IDLE;
					state      <= ST_WAIT;
				end
				ST_WAIT: begin
					if (count == '0)
						state <= next_state;
					else
						count <= count - 1'b1;
				end
				default: state <= ST_STARTUP;
			endcase
		end
	end

	// ==============================
	// Data path
	// ==============================

	// Chip samples READ one edge after cmd_q loads; beat 0 lands in dq_in_q
	// CAS_LATENCY edges later, first beat is the high half.
	always_ff @(posedge i_clock) begin
		dq_in_q <= i_sdram_dq_in;
		if (|rd_pipe[CAP_FIRST +: BURST_COUNT])
			rsp_shift <= (rsp_shift << SDRAM_DATA_WIDTH) | USER_DATA_WIDTH'(dq_in_q);
		if (state == ST_WRITE) begin
			dq_out_q <= req.wdata[USER_DATA_WIDTH-1 -: SDRAM_DATA_WIDTH];	// With the command.
			wr_shift <= req.wdata << SDRAM_DATA_WIDTH;
		end else begin
			dq_out_q <= wr_shift[USER_DATA_WIDTH-1 -: SDRAM_DATA_WIDTH];
			wr_shift <= wr_shift << SDRAM_DATA_WIDTH;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rd_pipe     <= '0;
			rsp_valid_q <= 1'b0;
			dq_oe_q     <= 1'b0;
			wr_left     <= '0;
		end else begin
			rd_pipe     <= {rd_pipe[PIPE_LEN-2:0], state == ST_READ};
			rsp_valid_q <= rd_pipe[PIPE_LEN-1];	// Last beat captured.
			if (state == ST_WRITE) begin
				dq_oe_q <= 1'b1;
				wr_left <= LEFT_W'(BURST_COUNT - 1);
			end else if (wr_left != '0) begin
				wr_left <= wr_left - 1'b1;
			end else begin
				dq_oe_q <= 1'b0;
			end
		end
	end

	assign o_sdram_cke    = cke_q;
	assign o_sdram_dqm    = {(SDRAM_DATA_WIDTH/8){~cke_q}};	// Low once the clock runs.
	assign o_sdram_cs_n   = cmd_q[3];
	assign o_sdram_ras_n  = cmd_q[2];
	assign o_sdram_cas_n  = cmd_q[1];
	assign o_sdram_we_n   = cmd_q[0];
	assign o_sdram_ba     = ba_q;
	assign o_sdram_addr   = addr_q;
	assign o_sdram_dq_out = dq_out_q;
	assign o_sdram_dq_oe  = dq_oe_q;
	assign o_rsp_valid    = rsp_valid_q;
	assign o_rsp_rdata    = rsp_shift;

endmodule

// ==== sdram_ctrl_asserts.sv ====
/*
 Protocol assertions for the SDRAM controller, bound to sdram_ctrl_top.
*/
`timescale 1ns/10ps

module sdram_ctrl_asserts (
	input logic i_clock,
	input logic i_reset,
	input logic i_req_ready,
	input logic i_rsp_valid,
	input logic i_cs_n,
	input logic i_ras_n,
	input logic i_cas_n,
	input logic i_we_n,
	input logic i_dq_oe
);
	logic is_set_mode;
	logic is_write;
	logic mode_seen_q;

	assign is_set_mode = {i_cs_n, i_ras_n, i_cas_n, i_we_n} == sdram_pkg::CMD_SET_MODE;
	assign is_write    = {i_cs_n, i_ras_n, i_cas_n, i_we_n} == sdram_pkg::CMD_WRITE;

	always_ff @(posedge i_clock) begin
		if (i_reset)
			mode_seen_q <= 1'b0;
		else if (is_set_mode)
			mode_seen_q <= 1'b1;
	end

	// No request before the mode register is set.
	ready_after_init: assert property (@(posedge i_clock) disable iff (i_reset)
		i_req_ready |-> (mode_seen_q || is_set_mode))
		else $error("request port ready before mode register set");

	write_data_window: assert property (@(posedge i_clock) disable iff (i_reset)
		i_dq_oe |-> (is_write || $past(is_write)))
		else $error("data bus driven outside a write burst");

	rsp_single_cycle: assert property (@(posedge i_clock) disable iff (i_reset)
		i_rsp_valid |=> !i_rsp_valid)
		else $error("response valid held for two cycles");

endmodule

bind sdram_ctrl_top sdram_ctrl_asserts u_asserts (
	.i_clock     (i_clock),
	.i_reset     (i_reset),
	.i_req_ready (o_req_ready),
	.i_rsp_valid (o_rsp_valid),
	.i_cs_n      (o_sdram_cs_n),
	.i_ras_n     (o_sdram_ras_n),
	.i_cas_n     (o_sdram_cas_n),
	.i_we_n      (o_sdram_we_n),
	.i_dq_oe     (o_sdram_dq_oe)
);

// ==== sdram_ctrl_top.sv ====
/*
 SDR SDRAM controller top level. Connects the request front end,
 one row tracker per bank and the command sequencer.
*/
`timescale 1ns/10ps

module sdram_ctrl_top #(
	parameter int USER_DATA_WIDTH  = 32,
	parameter int SDRAM_DATA_WIDTH = 16,
	parameter int STARTUP_CYCLES   = 20000,
	parameter int REFRESH_INTERVAL = 500
) (
	input  logic                          i_clock,
	input  logic                          i_reset,

	// User port.
	input  logic                          i_req_valid,
	output logic                          o_req_ready,
	input  logic                          i_req_write,
	input  sdram_pkg::byte_addr_t         i_req_addr,	// 4-byte aligned.
	input  logic [USER_DATA_WIDTH-1:0]    i_req_wdata,
	output logic                          o_rsp_valid,
	output logic [USER_DATA_WIDTH-1:0]    o_rsp_rdata,

	// Chip pins.
	output logic                          o_sdram_cke,
	output logic                          o_sdram_cs_n,
	output logic                          o_sdram_ras_n,
	output logic                          o_sdram_cas_n,
	output logic                          o_sdram_we_n,
	output logic [SDRAM_DATA_WIDTH/8-1:0] o_sdram_dqm,
	output sdram_pkg::bank_t              o_sdram_ba,
	output sdram_pkg::addr_bus_t          o_sdram_addr,
	output logic [SDRAM_DATA_WIDTH-1:0]   o_sdram_dq_out,
	output logic                          o_sdram_dq_oe,
	input  logic [SDRAM_DATA_WIDTH-1:0]   i_sdram_dq_in
);
	sdram_pkg::bank_t pend_bank;
	sdram_pkg::row_t  pend_row;

	sdram_req_if #(.DATA_WIDTH(USER_DATA_WIDTH)) req_if ();
	sdram_bank_if bank_if [sdram_pkg::NUM_BANKS] ();

	sdram_req_front #(
		.USER_DATA_WIDTH (USER_DATA_WIDTH)
	) u_front (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_req_valid (i_req_valid),
		.o_req_ready (o_req_ready),
		.i_req_write (i_req_write),
		.i_req_addr  (i_req_addr),
		.i_req_wdata (i_req_wdata),
		.o_pend_bank (pend_bank),
		.o_pend_row  (pend_row),
		.req         (req_if.front)
	);

	// One open-row tracker per bank.
	for (genvar b = 0; b < sdram_pkg::NUM_BANKS; b++) begin : g_bank_row
		sdram_bank_row u_row (
			.i_clock    (i_clock),
			.i_reset    (i_reset),
			.i_pend_row (pend_row),
			.trk        (bank_if[b].tracker)
		);
	end

	sdram_cmd_seq #(
		.USER_DATA_WIDTH  (USER_DATA_WIDTH),
		.SDRAM_DATA_WIDTH (SDRAM_DATA_WIDTH),
		.STARTUP_CYCLES   (STARTUP_CYCLES),
		.REFRESH_INTERVAL (REFRESH_INTERVAL)
	) u_seq (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.req            (req_if.seq),
		.bank_if        (bank_if),
		.i_pend_bank    (pend_bank),
		.o_sdram_cke    (o_sdram_cke),
		.o_sdram_cs_n   (o_sdram_cs_n),
		.o_sdram_ras_n  (o_sdram_ras_n),
		.o_sdram_cas_n  (o_sdram_cas_n),
		.o_sdram_we_n   (o_sdram_we_n),
		.o_sdram_dqm    (o_sdram_dqm),
		.o_sdram_ba     (o_sdram_ba),
		.o_sdram_addr   (o_sdram_addr),
		.o_sdram_dq_out (o_sdram_dq_out),
		.o_sdram_dq_oe  (o_sdram_dq_oe),
		.i_sdram_dq_in  (i_sdram_dq_in),
		.o_rsp_valid    (o_rsp_valid),
		.o_rsp_rdata    (o_rsp_rdata)
	);

endmodule

// ==== sdram_ifs.sv ====
/*
 Internal interfaces of the SDRAM controller.
 sdram_req_if carries the pending request from front end to sequencer,
 sdram_bank_if links one bank tracker to the sequencer.
*/
`timescale 1ns/10ps

interface sdram_req_if #(
	parameter int DATA_WIDTH = 32
);
	logic                  valid;	// Front end holds a request.
	logic                  ready;	// Sequencer takes it, slot empties.
	logic                  write;
	sdram_pkg::bank_t      bank;
	sdram_pkg::row_t       row;
	sdram_pkg::col_t       col;
	logic [DATA_WIDTH-1:0] wdata;

	modport front (
		output valid, write, bank, row, col, wdata,
		input  ready
	);

	modport seq (
		input  valid, write, bank, row, col, wdata,
		output ready
	);
endinterface

interface sdram_bank_if;
	sdram_pkg::row_state_t status;
	sdram_pkg::row_t       open_row;
	logic                  activate;	// Store pending row.
	logic                  precharge;	// Close this bank.
	logic                  precharge_all;

	modport tracker (
		output status, open_row,
		input  activate, precharge, precharge_all
	);

	modport seq (
		input  status, open_row,
		output activate, precharge, precharge_all
	);
endinterface

// ==== sdram_pkg.sv ====
/*
 Shared types and constants of the SDR SDRAM controller.
 RTL and testbench refer to them by scoped name.
*/
package sdram_pkg;

	// ==============================
	// Address fields
	// ==============================

	localparam int NUM_BANKS = 4;

	typedef logic [31:0] byte_addr_t;	// User byte address.
	typedef logic [1:0]  bank_t;
	typedef logic [12:0] row_t;
	typedef logic [8:0]  col_t;		// Bit 0 stays zero, two beats per word.
	typedef logic [12:0] addr_bus_t;	// Chip address pins.

	// Chip command as {cs_n, ras_n, cas_n, we_n}.
	typedef enum logic [3:0] {
		CMD_NOP       = 4'b0111,
		CMD_PRECHARGE = 4'b0010,
		CMD_SET_MODE  = 4'b0000,
		CMD_REFRESH   = 4'b0001,
		CMD_ACTIVATE  = 4'b0011,
		CMD_READ      = 4'b0101,
		CMD_WRITE     = 4'b0100
	} cmd_t;

	// Bank status seen by the pending request.
	typedef enum logic [1:0] {
		ROW_IDLE     = 2'd0,	// Bank closed.
		ROW_HIT      = 2'd1,
		ROW_CONFLICT = 2'd2	// Another row is open.
	} row_state_t;

	// ==============================
	// Timing, in clock cycles
	// ==============================

	localparam int CAS_LATENCY = 2;
	localparam int T_RP        = 1;
	localparam int T_RFC       = 7;
	localparam int T_MRD       = 2;
	localparam int T_ACT       = 1;

	// Mode register: programmed write burst, CAS latency, sequential, burst length.
	function automatic addr_bus_t MODE_WORD(input int burst_count);
		logic [2:0] bl_code;
		case (burst_count)
			1:       bl_code = 3'b000;
			2:       bl_code = 3'b001;
			4:       bl_code = 3'b010;
			default: bl_code = 3'b011;
		endcase
		return {3'b000, 1'b0, 2'b00, 3'(CAS_LATENCY), 1'b0, bl_code};
	endfunction

endpackage

// ==== sdram_req_front.sv ====
/*
 Request front end. Takes user requests by valid/ready into a
 one-entry slot and splits the byte address into bank, row and column.
*/
`timescale 1ns/10ps

module sdram_req_front #(
	parameter int USER_DATA_WIDTH = 32
) (
	input  logic                       i_clock,
	input  logic                       i_reset,
	input  logic                       i_req_valid,
	output logic                       o_req_ready,
	input  logic                       i_req_write,
	input  sdram_pkg::byte_addr_t      i_req_addr,
	input  logic [USER_DATA_WIDTH-1:0] i_req_wdata,
	output sdram_pkg::bank_t           o_pend_bank,
	output sdram_pkg::row_t            o_pend_row,
	sdram_req_if.front                 req
);
	logic                       full_q;
	logic                       open_q;	// Set by the first ready, after init.
	logic                       accept;
	logic                       write_q;
	sdram_pkg::bank_t           bank_q;
	sdram_pkg::row_t            row_q;
	sdram_pkg::col_t            col_q;
	logic [USER_DATA_WIDTH-1:0] wdata_q;

	assign o_req_ready = open_q && !full_q;
	assign accept      = i_req_valid && o_req_ready;

	// Slot control.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			full_q <= 1'b0;
			open_q <= 1'b0;
		end else begin
			if (req.ready) begin
				open_q <= 1'b1;
				full_q <= 1'b0;
			end else if (accept) begin
				full_q <= 1'b1;
			end
		end
	end

	// Word address bits 22..10 row, 9..8 bank, 7..0 column pair.
	always_ff @(posedge i_clock) begin
		if (accept) begin
			write_q <= i_req_write;
			row_q   <= i_req_addr[24:12];
			bank_q  <= i_req_addr[11:10];
			col_q   <= {i_req_addr[9:2], 1'b0};
			wdata_q <= i_req_wdata;
		end
	end

	assign req.valid   = full_q;
	assign req.write   = write_q;
	assign req.bank    = bank_q;
	assign req.row     = row_q;
	assign req.col     = col_q;
	assign req.wdata   = wdata_q;
	assign o_pend_bank = bank_q;
	assign o_pend_row  = row_q;

endmodule

// ==== tb_sdram_ctrl.sv ====
/*
 Testbench for the SDRAM controller. Directed tests drive the user port,
 a chip model sits on the pins, read data is checked against a shadow memory.
*/
`timescale 1ns/10ps

module tb_sdram_ctrl;

	localparam int MAX_CYCLES = 20000;	// Start-up plus about 150 requests.

	logic        i_clock;
	logic        i_reset;
	logic        i_req_valid;
	logic        o_req_ready;
	logic        i_req_write;
	logic [31:0] i_req_addr;
	logic [31:0] i_req_wdata;
	logic        o_rsp_valid;
	logic [31:0] o_rsp_rdata;
	logic        cke, cs_n, ras_n, cas_n, we_n, dq_oe;
	logic [1:0]  dqm, ba;
	logic [12:0] addr;
	logic [15:0] dq_out, dq_in;

	logic [31:0]     shadow [logic [22:0]];
	logic [31:0]     expect_q [$];
	sdram_pkg::cmd_t init_cmd [$];
	logic [12:0]     init_addr [$];
	string           test_name = "reset";
	integer          seed = 32'h0f23_f837;
	int              errors = 0;
	int              checks = 0;
	int              cycles = 0;
	int              n_activate = 0;
	int              n_refresh = 0;
	int              n_prech_all = 0;
	int              n_prech_bank [4] = '{0, 0, 0, 0};
	logic            mode_seen = 1'b0;
	logic            bank_open [4] = '{1'b0, 1'b0, 1'b0, 1'b0};
	sdram_pkg::cmd_t pin_cmd;

	sdram_ctrl_top #(
		.USER_DATA_WIDTH  (32),
		.SDRAM_DATA_WIDTH (16),
		.STARTUP_CYCLES   (200),
		.REFRESH_INTERVAL (300)
	) dut0 (
		.i_clock (i_clock), .i_reset (i_reset),
		.i_req_valid (i_req_valid), .o_req_ready (o_req_ready),
		.i_req_write (i_req_write), .i_req_addr (i_req_addr),
		.i_req_wdata (i_req_wdata), .o_rsp_valid (o_rsp_valid),
		.o_rsp_rdata (o_rsp_rdata), .o_sdram_cke (cke),
		.o_sdram_cs_n (cs_n), .o_sdram_ras_n (ras_n),
		.o_sdram_cas_n (cas_n), .o_sdram_we_n (we_n),
		.o_sdram_dqm (dqm), .o_sdram_ba (ba), .o_sdram_addr (addr),
		.o_sdram_dq_out (dq_out), .o_sdram_dq_oe (dq_oe),
		.i_sdram_dq_in (dq_in)
	);

	tb_sdram_model chip0 (
		.i_clock (i_clock), .i_cke (cke), .i_cs_n (cs_n), .i_ras_n (ras_n),
		.i_cas_n (cas_n), .i_we_n (we_n), .i_ba (ba), .i_addr (addr),
		.i_dq (dq_out), .i_dq_oe (dq_oe), .o_dq (dq_in)
	);

	initial begin
		i_clock = 1'b0;
		forever #50 i_clock = ~i_clock;
	end

	// ==============================
	// Pin monitor and timeout
	// ==============================

	assign pin_cmd = sdram_pkg::cmd_t'({cs_n, ras_n, cas_n, we_n});

	always @(posedge i_clock) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles in test %s", cycles, test_name);
			$display("tests failed");
			$finish;
		end
	end

	always @(posedge i_clock) begin
		if (!i_reset && cke && pin_cmd != sdram_pkg::CMD_NOP) begin
			if (!mode_seen) begin
				init_cmd.push_back(pin_cmd);
				init_addr.push_back(addr);
			end
			case (pin_cmd)
				sdram_pkg::CMD_SET_MODE: mode_seen = 1'b1;
				sdram_pkg::CMD_REFRESH:  n_refresh++;
				sdram_pkg::CMD_ACTIVATE: begin
					n_activate++;
					if (bank_open[ba]) begin
						errors++;
						$display("ERROR in %s: ACTIVATE to bank %0d while a row is open",
							test_name, ba);
					end
					bank_open[ba] = 1'b1;
				end
				sdram_pkg::CMD_PRECHARGE: begin
					if (addr[10]) begin
						n_prech_all++;
						bank_open = '{1'b0, 1'b0, 1'b0, 1'b0};
					end else begin
						n_prech_bank[ba]++;
						bank_open[ba] = 1'b0;
					end
				end
				default: ;
			endcase
		end
		if (!i_reset && cke && dqm != 2'b00) begin
			errors++;
			$display("ERROR in %s: DQM high while the clock is enabled", test_name);
		end
		if (!i_reset && o_req_ready && !mode_seen) begin
			errors++;
			$display("ERROR: request port ready before the mode register was set");
		end
	end

	// ==============================
	// Helpers
	// ==============================

	task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	// Read responses arrive in request order.
	always @(negedge i_clock) begin
		if (o_rsp_valid) begin
			if (expect_q.size() == 0) begin
				errors++;
				$display("ERROR in %s: read response with no read outstanding", test_name);
			end else begin
				check_value(expect_q.pop_front(), o_rsp_rdata);
			end
		end
	end

	function automatic logic [31:0] make_addr(input int bank, input int row, input int col);
		return {7'd0, 13'(row), 2'(bank), 8'(col), 2'b00};
	endfunction

	// Called at a falling edge; returns at the falling edge after the transfer.
	task automatic send(input logic write, input logic [31:0] a, input logic [31:0] d);
		i_req_valid = 1'b1;
		i_req_write = write;
		i_req_addr  = a;
		i_req_wdata = d;
		while (!o_req_ready)
			@(negedge i_clock);
		if (write)
			shadow[a[24:2]] = d;
		else
			expect_q.push_back(shadow.exists(a[24:2]) ? shadow[a[24:2]] : 32'h0);
		@(negedge i_clock);
		i_req_valid = 1'b0;
	endtask

	task automatic wait_done();
		while (expect_q.size() != 0 || !o_req_ready)
			@(negedge i_clock);
		repeat (4) @(negedge i_clock);
	endtask

	// Start right after a refresh, so none falls inside a short test.
	task automatic sync_to_refresh();
		int start;
		start = n_refresh;
		while (n_refresh == start)
			@(negedge i_clock);
		repeat (10) @(negedge i_clock);
	endtask

	// ==============================
	// Tests
	// ==============================

	task automatic test_init();
		test_name = "init";
		check_value(0, cke);
		while (!mode_seen)
			@(negedge i_clock);
		check_value(4, init_cmd.size());
		if (init_cmd.size() == 4) begin
			check_value(sdram_pkg::CMD_PRECHARGE, init_cmd[0]);
			check_value(1, init_addr[0][10]);
			check_value(sdram_pkg::CMD_REFRESH, init_cmd[1]);
			check_value(sdram_pkg::CMD_REFRESH, init_cmd[2]);
			check_value(sdram_pkg::CMD_SET_MODE, init_cmd[3]);
			check_value(13'h021, init_addr[3]);	// CAS latency 2 and a burst of 2.
		end
	endtask

	task automatic test_row_hit();
		int act0;
		test_name = "row_hit";
		sync_to_refresh();
		act0 = n_activate;
		send(1'b1, make_addr(1, 5, 4), 32'hcafe_0001);
		send(1'b0, make_addr(1, 5, 4), 0);
		send(1'b1, make_addr(1, 5, 9), 32'h1234_5678);
		send(1'b0, make_addr(1, 5, 9), 0);
		wait_done();
		check_value(1, n_activate - act0);
	endtask

	task automatic test_row_conflict();
		int pre0;
		test_name = "row_conflict";
		sync_to_refresh();
		pre0 = n_prech_bank[2];
		send(1'b1, make_addr(2, 10, 3), 32'h0a0a_5555);
		send(1'b1, make_addr(2, 20, 3), 32'hb0b0_6666);
		send(1'b0, make_addr(2, 10, 3), 0);
		send(1'b0, make_addr(2, 20, 3), 0);
		wait_done();
		if (n_prech_bank[2] == pre0) begin
			errors++;
			$display("ERROR in %s: no bank precharge seen on a row conflict", test_name);
		end
	endtask

	task automatic test_interleave();
		test_name = "interleave";
		for (int i = 0; i < 8; i++)
			send(1'b1, make_addr(i % 4, 40 + i, i), $random(seed));
		for (int i = 0; i < 8; i++)
			send(1'b0, make_addr(i % 4, 40 + i, i), 0);
		wait_done();
	endtask

	task automatic test_refresh();
		int   ref0;
		int   pa0;
		logic was_open;
		test_name = "refresh";
		ref0     = n_refresh;
		pa0      = n_prech_all;
		was_open = bank_open[0] || bank_open[1] || bank_open[2] || bank_open[3];
		repeat (400) @(negedge i_clock);
		if (n_refresh == ref0 || (was_open && n_prech_all == pa0)) begin
			errors++;
			$display("ERROR in %s: idle period without precharge-all and refresh", test_name);
		end
		for (int i = 0; i < 8; i++)
			send(1'b0, make_addr(i % 4, 40 + i, i), 0);
		wait_done();
	endtask

	task automatic test_random();
		logic [31:0] a;
		test_name = "random";
		for (int i = 0; i < 100; i++) begin
			a = make_addr($random(seed) & 3, $random(seed) & 7, $random(seed) & 255);
			send($random(seed) & 1, a, $random(seed));
		end
		wait_done();
	endtask

	initial begin
		i_reset     = 1'b1;
		i_req_valid = 1'b0;
		i_req_write = 1'b0;
		i_req_addr  = 32'h0;
		i_req_wdata = 32'h0;
		repeat (5) @(negedge i_clock);
		i_reset = 1'b0;
		test_init();
		test_row_hit();
		test_row_conflict();
		test_interleave();
		test_refresh();
		test_random();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== tb_sdram_model.sv ====
/*
 Behavioural SDR SDRAM chip for the testbench. Decodes the command pins,
 keeps data in a sparse array and returns read bursts after CAS latency.
*/
`timescale 1ns/10ps

module tb_sdram_model (
	input  logic        i_clock,
	input  logic        i_cke,
	input  logic        i_cs_n,
	input  logic        i_ras_n,
	input  logic        i_cas_n,
	input  logic        i_we_n,
	input  logic [1:0]  i_ba,
	input  logic [12:0] i_addr,
	input  logic [15:0] i_dq,
	input  logic        i_dq_oe,
	output logic [15:0] o_dq
);
	logic [15:0] mem [logic [23:0]];	// Key is {bank, row, column}.
	logic [12:0] open_row [4];
	logic [1:0]  rd_shift = 2'b00;
	logic [23:0] rd_key;
	logic        wr_pend = 1'b0;
	logic [23:0] wr_key;
	sdram_pkg::cmd_t cmd;

	assign cmd = sdram_pkg::cmd_t'({i_cs_n, i_ras_n, i_cas_n, i_we_n});

	function automatic logic [15:0] read_beat(input logic [23:0] key);
		return mem.exists(key) ? mem[key] : 16'h0000;	// Unwritten cells read zero.
	endfunction

	initial o_dq = 16'h0000;

	always @(posedge i_clock) begin
		// Beat 0 one edge after the READ is sampled, beat 1 on the next.
		rd_shift <= {rd_shift[0], i_cke && (cmd == sdram_pkg::CMD_READ)};
		if (rd_shift[0])
			o_dq <= read_beat(rd_key);
		else if (rd_shift[1])
			o_dq <= read_beat(rd_key + 24'd1);

		if (wr_pend && i_dq_oe)
			mem[wr_key] = i_dq;	// Second beat of the write.
		wr_pend <= 1'b0;

		if (i_cke) begin
			case (cmd)
				sdram_pkg::CMD_ACTIVATE: open_row[i_ba] <= i_addr;
				sdram_pkg::CMD_READ:     rd_key <= {i_ba, open_row[i_ba], i_addr[8:0]};
				sdram_pkg::CMD_WRITE: begin
					mem[{i_ba, open_row[i_ba], i_addr[8:0]}] = i_dq;
					wr_key  <= {i_ba, open_row[i_ba], i_addr[8:0]} + 24'd1;
					wr_pend <= 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== verilog.f ====
sdram_pkg.sv
sdram_ifs.sv
sdram_req_front.sv
sdram_bank_row.sv
sdram_cmd_seq.sv
sdram_ctrl_top.sv
tb_sdram_model.sv
sdram_ctrl_asserts.sv
tb_sdram_ctrl.sv
